/* src/sharedFifoMonConsts.svh */
// Sizing constants for the shared multi-FIFO monitor.
// Number of FIFOs, shared depth, payload width and derived widths.
`ifndef SHARED_FIFO_MON_CONSTS_SVH
`define SHARED_FIFO_MON_CONSTS_SVH

// Number of logical FIFOs that share the storage.
`define SFM_NUM_FIFOS 2

// Total shared depth; also the credit count the sender starts with.
`define SFM_DEPTH 8

// Payload width of one entry.
`define SFM_DATA_WIDTH 8

// One bit wider than two FIFOs need, so that out-of-range ids can be observed.
`define SFM_FIFO_ID_WIDTH 2

// Counts run from 0 to the full depth; pointers address one shadow slot.
`define SFM_COUNT_WIDTH 4
`define SFM_ADDR_WIDTH 3

`endif

/* src/sharedFifoMonPkg.sv */
// Violation code enum and violation flag struct for the shared FIFO monitor.
package sharedFifoMonPkg;

    // Violation codes.
    // A lower value means a higher priority when several arrive in the same cycle.
    typedef enum logic [2:0] {
        vNone              = 3'd0,
        vPushNoCredit      = 3'd1,
        vCreditOverflow    = 3'd2,
        vBadFifoId         = 3'd3,
        vPopEmpty          = 3'd4,
        vDataMismatch      = 3'd5,
        vOccupancyOverflow = 3'd6
    } violationCodeT;

    // One flag per non-none code.
    // The flag for code N sits at bit N-1 of the packed vector, so pushNoCredit is the LSB.
    typedef struct packed {
        // Push seen while the full shared depth was already occupied.
        logic occupancyOverflow;
        // Popped data differed from the shadow head.
        logic dataMismatch;
        // Pop seen on a lane whose shadow queue was empty.
        logic popEmpty;
        // Push carried an id outside the range of logical FIFOs.
        logic badFifoId;
        // Credit returned while the sender already held every credit.
        logic creditOverflow;
        // Push seen while the sender held no credit.
        logic pushNoCredit;
    } violationFlagsT;

endpackage

/* src/sharedFifoMonIfs.sv */
// Observation bundles for the push side and the pop side of the watched FIFO.
// Both are passive; the monitor modport only reads.
`timescale 1ns/1ps
`include "sharedFifoMonConsts.svh"

// Push-side traffic.
// There is no ready here, since the credit loop takes its place.
interface pushObsIf;
    logic                          pushValid;
    logic [`SFM_DATA_WIDTH-1:0]    pushData;
    logic [`SFM_FIFO_ID_WIDTH-1:0] pushFifoId;
    // One credit handed back to the sender in this cycle.
    logic                          pushCredit;
    // Either side of the credit loop held in reset.
    logic                          senderInReset;
    logic                          receiverInReset;

    // Checkers only look at the traffic.
    modport monitor (
        input pushValid,
        input pushData,
        input pushFifoId,
        input pushCredit,
        input senderInReset,
        input receiverInReset
    );
endinterface

// Pop-side traffic, one lane per logical FIFO.
interface popObsIf;
    logic [`SFM_NUM_FIFOS-1:0]                          popValid;
    logic [`SFM_NUM_FIFOS-1:0]                          popReady;
    logic [`SFM_NUM_FIFOS-1:0][`SFM_DATA_WIDTH-1:0]     popData;

    // The order checker compares popped data against its shadow model.
    modport monitor (
        input popValid,
        input popReady,
        input popData
    );
endinterface

/* src/creditChecker.sv */
// Push credit accounting for the monitor.
// Tracks credits held by the sender and flags credit misuse.
`timescale 1ns/1ps
`include "sharedFifoMonConsts.svh"

module creditChecker
    import sharedFifoMonPkg::*;
(
    input  logic                        clk,
    input  logic                        rstN,
    pushObsIf.monitor                   push,
    output logic [`SFM_COUNT_WIDTH-1:0] creditCount,
    output violationFlagsT              flags
);

    localparam int CountW = `SFM_COUNT_WIDTH;
    localparam logic [CountW-1:0] MaxCredit = CountW'(`SFM_DEPTH);

    logic              inReset;
    logic [CountW-1:0] creditNext;
    violationFlagsT    flagsNext;

    // While either end of the loop is in reset, the credit state is reloaded.
    assign inReset = push.senderInReset | push.receiverInReset;

    // Next credit count and violation pulse for the current cycle.
    always_comb begin
        creditNext = creditCount;
        flagsNext  = '0;
        if (push.pushValid && !push.pushCredit) begin
            // A push spends one credit.
            // With none left, the push is illegal and the count holds at zero.
            if (creditCount == '0) begin
                flagsNext.pushNoCredit = 1'b1;
            end else begin
                creditNext = creditCount - CountW'(1);
            end
        end else if (push.pushCredit && !push.pushValid) begin
            // A return gives one credit back.
            // The sender can never hold more than the shared depth.
            if (creditCount == MaxCredit) begin
                flagsNext.creditOverflow = 1'b1;
            end else begin
                creditNext = creditCount + CountW'(1);
            end
        end
        // A push and a return together leave the count where it is.
    end

    // Count and flag pulse are both updated on the sampling edge.
    always_ff @(posedge clk) begin
        if (!rstN || inReset) begin
            creditCount <= MaxCredit;
            flags       <= '0;
        end else begin
            creditCount <= creditNext;
            flags       <= flagsNext;
        end
    end

endmodule

/* src/fifoOrderChecker.sv */
// Shadow model of each logical FIFO in the shared storage.
// Flags bad ids, ordering errors, occupancy overflow and pops from empty queues.
`timescale 1ns/1ps
`include "sharedFifoMonConsts.svh"

module fifoOrderChecker
    import sharedFifoMonPkg::*;
(
    input  logic           clk,
    input  logic           rstN,
    pushObsIf.monitor      push,
    popObsIf.monitor       pop,
    output violationFlagsT flags
);

    localparam int NumFifos = `SFM_NUM_FIFOS;
    localparam int Depth    = `SFM_DEPTH;
    localparam int DataW    = `SFM_DATA_WIDTH;
    localparam int CountW   = `SFM_COUNT_WIDTH;
    localparam int AddrW    = `SFM_ADDR_WIDTH;

    logic                 inReset;
    logic                 pushAccept;
    logic [NumFifos-1:0]  popAccept;
    violationFlagsT       flagsNext;
    logic [CountW-1:0]    totalNext;
    logic [CountW-1:0]    totalCount;

    // Per-queue storage and state.
    // Each queue could take the whole shared depth on its own.
    logic [DataW-1:0]     shadowMem  [NumFifos][Depth];
    logic [AddrW-1:0]     wrPtr      [NumFifos];
    logic [AddrW-1:0]     rdPtr      [NumFifos];
    logic [CountW-1:0]    queueCount [NumFifos];

    // Advance a circular pointer, wrapping at the queue depth.
    function automatic logic [AddrW-1:0] nextPtr(input logic [AddrW-1:0] ptr);
        return (int'(ptr) == Depth - 1) ? '0 : ptr + AddrW'(1);
    endfunction

    assign inReset = push.senderInReset | push.receiverInReset;

    // Classify the push and the pops seen in this cycle.
    always_comb begin
        flagsNext  = '0;
        pushAccept = 1'b0;
        popAccept  = '0;
        totalNext  = totalCount;
        if (push.pushValid) begin
            // An id outside the FIFO range is rejected before the occupancy check.
            if (int'(push.pushFifoId) >= NumFifos) begin
                flagsNext.badFifoId = 1'b1;
            end else if (int'(totalCount) == Depth) begin
                flagsNext.occupancyOverflow = 1'b1;
            end else begin
                pushAccept = 1'b1;
                totalNext  = totalNext + CountW'(1);
            end
        end
        for (int i = 0; i < NumFifos; i++) begin
            if (pop.popValid[i] && pop.popReady[i]) begin
                if (queueCount[i] == '0) begin
                    flagsNext.popEmpty = 1'b1;
                end else begin
                    // A wrong value still consumes the head, so later pops stay aligned.
                    if (pop.popData[i] != shadowMem[i][rdPtr[i]]) begin
                        flagsNext.dataMismatch = 1'b1;
                    end
                    popAccept[i] = 1'b1;
                    totalNext    = totalNext - CountW'(1);
                end
            end
        end
    end

    // Queue state and flag pulse.
    // Nothing observed during an in-reset cycle reaches the model.
    always_ff @(posedge clk) begin
        if (!rstN || inReset) begin
            totalCount <= '0;
            flags      <= '0;
            for (int i = 0; i < NumFifos; i++) begin
                wrPtr[i]      <= '0;
                rdPtr[i]      <= '0;
                queueCount[i] <= '0;
            end
        end else begin
            totalCount <= totalNext;
            flags      <= flagsNext;
            for (int i = 0; i < NumFifos; i++) begin
                if (pushAccept && int'(push.pushFifoId) == i) begin
                    wrPtr[i] <= nextPtr(wrPtr[i]);
                    if (!popAccept[i]) begin
                        queueCount[i] <= queueCount[i] + CountW'(1);
                    end
                end else if (popAccept[i]) begin
                    queueCount[i] <= queueCount[i] - CountW'(1);
                end
                if (popAccept[i]) begin
                    rdPtr[i] <= nextPtr(rdPtr[i]);
                end
            end
        end
    end

    // Each accepted push stores its payload at the write pointer of its queue.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NumFifos; i++) begin
            if (pushAccept && !inReset && int'(push.pushFifoId) == i) begin
                shadowMem[i][wrPtr[i]] <= push.pushData;
            end
        end
    end

endmodule

/* src/violationCollector.sv */
// Merges the checker pulses into sticky flags, the first violation code
// and a saturating count of cycles that brought a new violation.
`timescale 1ns/1ps
`include "sharedFifoMonConsts.svh"

module violationCollector
    import sharedFifoMonPkg::*;
(
    input  logic                        clk,
    input  logic                        rstN,
    input  violationFlagsT              creditFlags,
    input  violationFlagsT              orderFlags,
    output violationFlagsT              stickyFlags,
    output violationCodeT               firstViolation,
    output logic [`SFM_COUNT_WIDTH-1:0] violationCount
);

    localparam int CountW = `SFM_COUNT_WIDTH;

    violationFlagsT pulse;
    violationFlagsT newBits;

    // Lowest-valued code among the set flags.
    function automatic violationCodeT lowestCode(input violationFlagsT f);
        violationCodeT code;
        code = vNone;
        if (f.pushNoCredit) code = vPushNoCredit;
        else if (f.creditOverflow) code = vCreditOverflow;
        else if (f.badFifoId) code = vBadFifoId;
        else if (f.popEmpty) code = vPopEmpty;
        else if (f.dataMismatch) code = vDataMismatch;
        else if (f.occupancyOverflow) code = vOccupancyOverflow;
        return code;
    endfunction

    assign pulse = creditFlags | orderFlags;

    // A repeat of an already sticky flag is not counted again.
    assign newBits = pulse & ~stickyFlags;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stickyFlags    <= '0;
            firstViolation <= vNone;
            violationCount <= '0;
        end else begin
            stickyFlags <= stickyFlags | pulse;
            // Only the very first violation is latched.
            if (firstViolation == vNone && pulse != '0) begin
                firstViolation <= lowestCode(pulse);
            end
            // Saturate rather than wrap.
            if (newBits != '0 && violationCount != {CountW{1'b1}}) begin
                violationCount <= violationCount + CountW'(1);
            end
        end
    end

endmodule

/* src/sharedFifoMon.sv */
// Top level of the shared multi-FIFO monitor.
// Plain observation ports, the two bundles, both checkers and the collector.
`timescale 1ns/1ps
`include "sharedFifoMonConsts.svh"

module sharedFifoMon
    import sharedFifoMonPkg::*;
(
    input  logic                                        clk,
    input  logic                                        rstN,
    // Push side of the watched FIFO.
    input  logic                                        pushValid,
    input  logic [`SFM_DATA_WIDTH-1:0]                  pushData,
    input  logic [`SFM_FIFO_ID_WIDTH-1:0]               pushFifoId,
    input  logic                                        pushCredit,
    input  logic                                        senderInReset,
    input  logic                                        receiverInReset,
    // Pop side, one lane per logical FIFO.
    input  logic [`SFM_NUM_FIFOS-1:0]                   popValid,
    input  logic [`SFM_NUM_FIFOS-1:0]                   popReady,
    input  logic [`SFM_NUM_FIFOS-1:0][`SFM_DATA_WIDTH-1:0] popData,
    // Monitor results.
    output logic [$bits(violationFlagsT)-1:0]           errorFlags,
    output violationCodeT                               firstViolation,
    output logic [`SFM_COUNT_WIDTH-1:0]                 violationCount,
    output logic [`SFM_COUNT_WIDTH-1:0]                 creditCount
);

    violationFlagsT creditFlags;
    violationFlagsT orderFlags;
    violationFlagsT stickyFlags;

    // Bundle the push traffic for both checkers.
    pushObsIf pushBus ();
    assign pushBus.pushValid       = pushValid;
    assign pushBus.pushData        = pushData;
    assign pushBus.pushFifoId      = pushFifoId;
    assign pushBus.pushCredit      = pushCredit;
    assign pushBus.senderInReset   = senderInReset;
    assign pushBus.receiverInReset = receiverInReset;

    // Pop traffic only goes to the order checker.
    popObsIf popBus ();
    assign popBus.popValid = popValid;
    assign popBus.popReady = popReady;
    assign popBus.popData  = popData;

    creditChecker i_creditChecker (
        .clk         (clk),
        .rstN        (rstN),
        .push        (pushBus),
        .creditCount (creditCount),
        .flags       (creditFlags)
    );

    fifoOrderChecker i_fifoOrderChecker (
        .clk   (clk),
        .rstN  (rstN),
        .push  (pushBus),
        .pop   (popBus),
        .flags (orderFlags)
    );

    // The collector adds the second cycle of flag latency.
    violationCollector i_violationCollector (
        .clk            (clk),
        .rstN           (rstN),
        .creditFlags    (creditFlags),
        .orderFlags     (orderFlags),
        .stickyFlags    (stickyFlags),
        .firstViolation (firstViolation),
        .violationCount (violationCount)
    );

    // Bit N-1 of the vector is the flag for code N.
    assign errorFlags = stickyFlags;

endmodule

/* verification/sharedFifoMonTb.sv */
// Trace-driven testbench for the shared multi-FIFO monitor.
// Reads stimulus and expected results, drives the DUT and checks its outputs.
`timescale 1ns/1ps
`include "sharedFifoMonConsts.svh"

module sharedFifoMonTb;

    localparam int DataW  = `SFM_DATA_WIDTH;
    localparam int IdW    = `SFM_FIFO_ID_WIDTH;
    localparam int Lanes  = `SFM_NUM_FIFOS;
    localparam int CountW = `SFM_COUNT_WIDTH;
    localparam int FlagW  = 6;
    localparam int CodeW  = 3;
    // One stimulus word per trace line, packed in the order of the DUT inputs.
    localparam int StimW  = 4 + IdW + DataW + 2 * Lanes + Lanes * DataW;
    // Expected flags, first code and credit count, flags in the top bits.
    localparam int ExpW   = FlagW + CodeW + CountW;
    localparam int ResetCycles = 3;
    localparam int FlushCycles = 2;
    localparam string TracePath = "verification/sharedFifoMonTrace.txt";

    logic                          clk;
    logic                          rstN;
    logic                          pushValid;
    logic [DataW-1:0]              pushData;
    logic [IdW-1:0]                pushFifoId;
    logic                          pushCredit;
    logic                          senderInReset;
    logic                          receiverInReset;
    logic [Lanes-1:0]              popValid;
    logic [Lanes-1:0]              popReady;
    logic [Lanes-1:0][DataW-1:0]   popData;
    logic [FlagW-1:0]              errorFlags;
    logic [CodeW-1:0]              firstViolation;
    logic [CountW-1:0]             violationCount;
    logic [CountW-1:0]             creditCount;

    logic [StimW-1:0] stimQ [$];
    logic [ExpW-1:0]  expQ [$];
    // Expectations waiting out the DUT latency; creditCount lags one cycle, flags two.
    logic [ExpW-1:0]  expD1;
    logic [ExpW-1:0]  expD2;
    int errorCount;
    int cycleCount;
    int cycleLimit;

    sharedFifoMon i_sharedFifoMon (
        .clk             (clk),
        .rstN            (rstN),
        .pushValid       (pushValid),
        .pushData        (pushData),
        .pushFifoId      (pushFifoId),
        .pushCredit      (pushCredit),
        .senderInReset   (senderInReset),
        .receiverInReset (receiverInReset),
        .popValid        (popValid),
        .popReady        (popReady),
        .popData         (popData),
        .errorFlags      (errorFlags),
        .firstViolation  (firstViolation),
        .violationCount  (violationCount),
        .creditCount     (creditCount)
    );

    // 20 ns clock period.
    always #10 clk = ~clk;

    // Watchdog on the clock; the limit comes from the trace length.
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the trace did not finish within %0d cycles", cycleLimit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic checkValue(input string field, input logic [15:0] actual,
                              input logic [15:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH at time %0t: %s is %0h, expected %0h",
                     $time, field, actual, expected);
        end
    endtask

    // Reads every data line of the trace into the stimulus and expectation queues.
    task automatic loadTrace(output bit ok);
        int fd;
        int n;
        int lineNo;
        string line;
        logic pv;
        logic cr;
        logic sr;
        logic rr;
        logic [IdW-1:0] id;
        logic [DataW-1:0] d;
        logic [Lanes-1:0] popV;
        logic [Lanes-1:0] popR;
        logic [DataW-1:0] p0;
        logic [DataW-1:0] p1;
        logic [FlagW-1:0] ef;
        logic [CodeW-1:0] fv;
        logic [CountW-1:0] ec;
        ok = 1'b0;
        lineNo = 0;
        fd = $fopen(TracePath, "r");
        if (fd == 0) begin
            $display("Cannot open the trace file %s", TracePath);
        end else begin
            while ($fgets(line, fd) != 0) begin
                lineNo++;
                // Comment lines and blank lines carry no stimulus.
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            pv, id, d, cr, sr, rr, popV, popR, p0, p1, ef, fv, ec);
                if (n != 13) begin
                    errorCount++;
                    $display("Trace line %0d could not be parsed", lineNo);
                end else begin
                    stimQ.push_back({pv, id, d, cr, sr, rr, popV, popR, p1, p0});
                    expQ.push_back({ef, fv, ec});
                end
            end
            $fclose(fd);
            ok = (stimQ.size() > 0);
            if (!ok) begin
                $display("The trace file holds no stimulus lines");
            end
        end
    endtask

    // One clock cycle: check what the last edge produced, then drive the next line.
    task automatic stepCycle(input logic [StimW-1:0] stim, input logic [ExpW-1:0] exp);
        @(posedge clk);
        #2;
        checkValue("creditCount", 16'(creditCount), 16'(expD1[CountW-1:0]));
        checkValue("errorFlags", 16'(errorFlags), 16'(expD2[ExpW-1:ExpW-FlagW]));
        checkValue("firstViolation", 16'(firstViolation),
                   16'(expD2[CountW+CodeW-1:CountW]));
        {pushValid, pushFifoId, pushData, pushCredit, senderInReset, receiverInReset,
         popValid, popReady, popData} = stim;
        expD2 = expD1;
        expD1 = exp;
    endtask

    // A line counts as a new violation when its expected flags gain a bit.
    function automatic int countNewViolations();
        logic [FlagW-1:0] prev;
        logic [FlagW-1:0] flags;
        int count;
        prev = '0;
        count = 0;
        foreach (expQ[i]) begin
            flags = expQ[i][ExpW-1:ExpW-FlagW];
            if ((flags & ~prev) != '0) begin
                count++;
            end
            prev = flags;
        end
        return count;
    endfunction

    initial begin
        bit loadOk;
        logic [ExpW-1:0] lastExp;
        clk = 1'b0;
        rstN = 1'b0;
        pushValid = 1'b0;
        pushData = '0;
        pushFifoId = '0;
        pushCredit = 1'b0;
        senderInReset = 1'b0;
        receiverInReset = 1'b0;
        popValid = '0;
        popReady = '0;
        popData = '0;
        errorCount = 0;
        cycleCount = 0;
        // After reset the monitor is clean and the sender holds every credit.
        expD1 = {FlagW'(0), CodeW'(0), CountW'(`SFM_DEPTH)};
        expD2 = expD1;
        loadTrace(loadOk);
        cycleLimit = ResetCycles + stimQ.size() + FlushCycles + 20;
        if (!loadOk) begin
            $display("Test failures found");
            $finish;
        end else begin
            repeat (ResetCycles) @(posedge clk);
            #2;
            rstN = 1'b1;
            foreach (stimQ[i]) begin
                stepCycle(stimQ[i], expQ[i]);
            end
            // Idle cycles let the last lines through the output latency.
            lastExp = expQ[expQ.size() - 1];
            repeat (FlushCycles) begin
                stepCycle('0, lastExp);
            end
            checkValue("violationCount", 16'(violationCount), 16'(countNewViolations()));
            $display("Checked %0d trace lines with %0d errors", stimQ.size(), errorCount);
            if (errorCount == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
            $finish;
        end
    end

endmodule

/* sharedFifoMon.f */
+incdir+src
src/sharedFifoMonPkg.sv
src/sharedFifoMonIfs.sv
src/creditChecker.sv
src/fifoOrderChecker.sv
src/violationCollector.sv
src/sharedFifoMon.sv
verification/sharedFifoMonTb.sv

/* run.sh */
#!/bin/sh
# Builds the monitor testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -f sharedFifoMon.f --top-module sharedFifoMonTb \
    --Mdir "$BUILD_DIR" -o sharedFifoMonSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"$BUILD_DIR/sharedFifoMonSim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0

/* verification/sharedFifoMonTrace.txt */
# pushValid pushFifoId pushData pushCredit senderInReset receiverInReset popValid popReady
# popData0 popData1 expErrorFlags expFirstViolation expCreditCount (hex; pop bit 0 is FIFO 0)
1 0 a1 0 0 0 0 0 00 00 00 0 7
1 1 b1 0 0 0 0 0 00 00 00 0 6
1 0 a2 0 0 0 0 0 00 00 00 0 5
0 0 00 1 0 0 1 0 a1 00 00 0 6
1 1 b2 0 0 0 1 1 a1 00 00 0 5
1 0 a3 1 0 0 3 3 a2 b1 00 0 5
0 0 00 1 0 0 0 0 00 00 00 0 6
0 0 00 1 0 0 2 2 00 b2 00 0 7
0 0 00 0 0 0 1 0 ff 00 00 0 7
0 0 00 1 0 0 1 1 a3 00 00 0 8
0 0 00 1 0 0 0 0 00 00 02 2 8
1 0 10 0 0 0 0 0 00 00 02 2 7
1 1 20 0 0 0 0 0 00 00 02 2 6
1 0 11 0 0 0 0 0 00 00 02 2 5
1 1 21 0 0 0 0 0 00 00 02 2 4
1 0 12 0 0 0 0 0 00 00 02 2 3
1 1 22 0 0 0 0 0 00 00 02 2 2
1 0 13 0 0 0 0 0 00 00 02 2 1
1 1 23 0 0 0 0 0 00 00 02 2 0
0 0 00 0 0 0 3 2 10 20 02 2 0
1 0 14 0 0 0 0 0 00 00 03 2 0
0 0 00 1 0 0 0 0 00 00 03 2 1
1 1 24 0 0 0 0 0 00 00 23 2 0
0 0 00 0 0 0 1 1 55 00 33 2 0
0 0 00 1 0 0 3 3 11 21 33 2 1
1 2 77 0 0 0 0 0 00 00 37 2 0
1 0 99 0 1 0 1 1 12 00 37 2 8
0 0 00 0 0 1 0 0 00 00 37 2 8
0 0 00 0 0 0 1 1 12 00 3f 2 8
1 1 30 0 0 0 0 0 00 00 3f 2 7
0 0 00 1 0 0 2 2 00 30 3f 2 8
0 0 00 0 0 0 0 0 00 00 3f 2 8
